/* verilog/cache_config.svh */
/*
 * Size settings of the two-way blocking cache
 */

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Geometry
`define CACHE_NSETS          8
`define CACHE_WORDS_PER_LINE 4

// Widths
`define CACHE_WORD_BITS      32
`define CACHE_ADDR_BITS      32
`define CACHE_LINE_BITS      128

// Address split, word offset counted in words
`define CACHE_IDX_BITS       3
`define CACHE_OFS_BITS       2
`define CACHE_TAG_BITS       25

`endif

/* verilog/cache_msg_pkg.sv */
/*
 * Message kinds on the processor and memory sides of the cache
 */

package cache_msg_pkg;

  // ----------------------------
  // Processor side
  // ----------------------------

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_type_e;

  // ----------------------------
  // Memory side, whole lines only
  // ----------------------------

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_type_e;

endpackage

/* verilog/cache_line_pkg.sv */
/*
 * Address fields and line storage types for the cache arrays
 */

`include "cache_config.svh"

package cache_line_pkg;

  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

  // Word address as seen by the tag check
  typedef struct packed {
    tag_t                       tag;
    logic [`CACHE_IDX_BITS-1:0] idx;
    logic [`CACHE_OFS_BITS-1:0] ofs;
    logic [1:0]                 byte_ofs;
  } addr_fields_t;

  // ----------------------------
  // One cache line
  // ----------------------------

  // Memory moves the flat vector
  // Word select and write merge use the word view
  typedef union packed {
    logic [`CACHE_LINE_BITS-1:0]                           bits;
    logic [`CACHE_WORDS_PER_LINE-1:0][`CACHE_WORD_BITS-1:0] words;
  } cache_line_u;

endpackage

/* verilog/cache_ctrl.sv */
/*
 * Control FSM of the blocking cache
 * Sequences tag check, data access, refill and eviction
 */

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cachereq_val,
  output logic                    cachereq_rdy,
  output logic                    cacheresp_val,
  input  logic                    cacheresp_rdy,
  output logic                    memreq_val,
  input  logic                    memreq_rdy,
  output cache_msg_pkg::mem_type_e memreq_type,
  input  logic                    memresp_val,
  output logic                    memresp_rdy,
  // Datapath enables
  output logic                    cachereq_en,
  output logic                    memresp_en,
  output logic                    tag_ren,
  output logic                    tag_wen,
  output logic                    data_ren,
  output logic                    data_wen,
  output logic                    is_refill,
  output logic                    read_data_reg_en,
  output logic                    evict_reg_en,
  // Line state updates
  output logic                    way_record_en,
  output logic                    valid_we,
  output logic                    dirty_we,
  output logic                    dirty_in,
  output logic                    lru_we,
  // Status
  input  logic                    hit,
  input  logic                    victim_dirty,
  input  logic                    req_is_write
);

  localparam logic [3:0] IDLE           = 4'd0;
  localparam logic [3:0] TAG_CHECK      = 4'd1;
  localparam logic [3:0] READ_ACCESS    = 4'd2;
  localparam logic [3:0] WRITE_ACCESS   = 4'd3;
  localparam logic [3:0] WAIT           = 4'd4;
  localparam logic [3:0] REFILL_REQUEST = 4'd5;
  localparam logic [3:0] REFILL_WAIT    = 4'd6;
  localparam logic [3:0] REFILL_UPDATE  = 4'd7;
  localparam logic [3:0] EVICT_PREPARE  = 4'd8;
  localparam logic [3:0] EVICT_REQUEST  = 4'd9;
  localparam logic [3:0] EVICT_WAIT     = 4'd10;

  logic [3:0]  state;
  logic [3:0]  state_next;
  logic [17:0] cs;
  logic        in_go;
  logic        out_go;

  assign in_go  = cachereq_val && cachereq_rdy;
  assign out_go = cacheresp_val && cacheresp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------
  // Next state
  // ----------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE:           if (in_go) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (hit) state_next = req_is_write ? WRITE_ACCESS : READ_ACCESS;
        else if (victim_dirty) state_next = EVICT_PREPARE;
        else state_next = REFILL_REQUEST;
      end
      READ_ACCESS:    state_next = WAIT;
      WRITE_ACCESS:   state_next = WAIT;
      REFILL_REQUEST: if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:    if (memresp_val) state_next = REFILL_UPDATE;
      // Replay the request on the fresh line
      REFILL_UPDATE:  state_next = req_is_write ? WRITE_ACCESS : READ_ACCESS;
      EVICT_PREPARE:  state_next = EVICT_REQUEST;
      EVICT_REQUEST:  if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:     if (memresp_val) state_next = REFILL_REQUEST;
      WAIT:           if (out_go) state_next = IDLE;
      default:        state_next = IDLE;
    endcase
  end

  // ----------------------------
  // Control table
  // ----------------------------

  //   cachereq_rdy    cacheresp_val   memreq_val      memresp_rdy
  //   cachereq_en     memresp_en      is_refill       tag_ren
  //   tag_wen         data_ren        data_wen        read_data_reg_en
  //   evict_reg_en    way_record_en   valid_we        dirty_we
  //   dirty_in        lru_we
  always_comb begin
    case (state)
      IDLE:           cs = 18'b1_0_0_0_1_0_0_0_0_0_0_0_0_0_0_0_0_0;
      TAG_CHECK:      cs = 18'b0_0_0_0_0_0_0_1_0_0_0_0_0_1_0_0_0_0;
      READ_ACCESS:    cs = 18'b0_0_0_0_0_0_0_0_0_1_0_1_0_0_0_0_0_1;
      WRITE_ACCESS:   cs = 18'b0_0_0_0_0_0_0_0_1_0_1_0_0_0_1_1_1_1;
      WAIT:           cs = 18'b0_1_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
      REFILL_REQUEST: cs = 18'b0_0_1_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
      REFILL_WAIT:    cs = 18'b0_0_0_1_0_1_0_0_0_0_0_0_0_0_0_0_0_0;
      REFILL_UPDATE:  cs = 18'b0_0_0_0_0_0_1_0_1_0_1_0_0_0_1_1_0_0;
      EVICT_PREPARE:  cs = 18'b0_0_0_0_0_0_0_1_0_1_0_0_1_0_0_0_0_0;
      EVICT_REQUEST:  cs = 18'b0_0_1_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
      EVICT_WAIT:     cs = 18'b0_0_0_1_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
      default:        cs = '0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy,
          cachereq_en, memresp_en, is_refill, tag_ren,
          tag_wen, data_ren, data_wen, read_data_reg_en,
          evict_reg_en, way_record_en, valid_we, dirty_we,
          dirty_in, lru_we} = cs;

  // Only the eviction writes memory
  assign memreq_type = (state == EVICT_REQUEST) ? cache_msg_pkg::MEM_WRITE
                                                : cache_msg_pkg::MEM_READ;

  // Handshakes hold until taken
  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val);

  cacheresp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val);

endmodule

/* verilog/cache_way_state.sv */
/*
 * Valid, dirty and LRU bits per set and way
 * Forms the hit and keeps the way chosen at tag check
 */

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_way_state (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`CACHE_IDX_BITS-1:0] idx,
  input  logic                       tag_match_0,
  input  logic                       tag_match_1,
  input  logic                       way_record_en,
  input  logic                       valid_we,
  input  logic                       dirty_we,
  input  logic                       dirty_in,
  input  logic                       lru_we,
  output logic                       hit,
  output logic                       victim_dirty,
  output logic                       way_sel
);

  logic [`CACHE_NSETS-1:0] valid [2];
  logic [`CACHE_NSETS-1:0] dirty [2];
  // Set bit names the least recently used way
  logic [`CACHE_NSETS-1:0] lru;

  logic hit_0;
  logic hit_1;
  logic lru_way;

  // ----------------------------
  // Lookup
  // ----------------------------

  assign hit_0   = valid[0][idx] && tag_match_0;
  assign hit_1   = valid[1][idx] && tag_match_1;
  assign hit     = hit_0 || hit_1;
  assign lru_way = lru[idx];

  // A dirty line is always valid
  assign victim_dirty = dirty[lru_way][idx];

  // ----------------------------
  // Update
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid   <= '{default: '0};
      dirty   <= '{default: '0};
      lru     <= '0;
      way_sel <= 1'b0;
    end else begin
      // Hitting way, else the victim
      if (way_record_en) begin
        way_sel <= hit ? hit_1 : lru_way;
      end
      if (valid_we) begin
        valid[way_sel][idx] <= 1'b1;
      end
      if (dirty_we) begin
        dirty[way_sel][idx] <= dirty_in;
      end
      if (lru_we) begin
        lru[idx] <= !way_sel;
      end
    end
  end

  // A tag sits in at most one way of a set
  one_way_hit: assert property (@(posedge clk) disable iff (reset)
    !(hit_0 && hit_1));

endmodule

/* verilog/cache_dpath.sv */
/*
 * Cache datapath with request register, tag and data arrays
 * and the registers that form memory messages
 */

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_dpath (
  input  logic                        clk,
  input  logic                        cachereq_en,
  input  cache_msg_pkg::req_type_e     cachereq_type,
  input  logic [`CACHE_ADDR_BITS-1:0] cachereq_addr,
  input  logic [`CACHE_WORD_BITS-1:0] cachereq_data,
  input  logic                        memresp_en,
  input  logic [`CACHE_LINE_BITS-1:0] memresp_data,
  input  logic                        tag_ren,
  input  logic                        tag_wen,
  input  logic                        data_ren,
  input  logic                        data_wen,
  input  logic                        is_refill,
  input  logic                        read_data_reg_en,
  input  logic                        evict_reg_en,
  input  logic                        way_sel,
  input  cache_msg_pkg::mem_type_e     memreq_type,
  output logic                        tag_match_0,
  output logic                        tag_match_1,
  output logic [`CACHE_IDX_BITS-1:0]  idx,
  output logic                        req_is_write,
  output cache_msg_pkg::req_type_e     cacheresp_type,
  output logic [`CACHE_WORD_BITS-1:0] cacheresp_data,
  output logic [`CACHE_ADDR_BITS-1:0] memreq_addr,
  output logic [`CACHE_LINE_BITS-1:0] memreq_data
);

  cache_msg_pkg::req_type_e     req_type;
  cache_line_pkg::addr_fields_t req_addr;
  logic [`CACHE_WORD_BITS-1:0]  req_data;

  cache_line_pkg::tag_t        tag_array [2][`CACHE_NSETS];
  cache_line_pkg::cache_line_u data_array [2][`CACHE_NSETS];

  cache_line_pkg::tag_t        read_tag_0;
  cache_line_pkg::tag_t        read_tag_1;
  cache_line_pkg::cache_line_u read_line;
  cache_line_pkg::cache_line_u write_line;
  cache_line_pkg::cache_line_u memresp_line;
  cache_line_pkg::cache_line_u evict_line;
  cache_line_pkg::tag_t        evict_tag;
  cache_line_pkg::tag_t        mem_tag;
  logic [`CACHE_WORDS_PER_LINE-1:0] word_en;

  // ----------------------------
  // Request and response
  // ----------------------------

  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      req_type <= cachereq_type;
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
    if (memresp_en) begin
      memresp_line.bits <= memresp_data;
    end
    if (read_data_reg_en) begin
      cacheresp_data <= read_line.words[req_addr.ofs];
    end
    if (evict_reg_en) begin
      evict_line <= read_line;
      evict_tag  <= way_sel ? read_tag_1 : read_tag_0;
    end
  end

  assign idx            = req_addr.idx;
  assign req_is_write   = (req_type == cache_msg_pkg::REQ_WRITE);
  assign cacheresp_type = req_type;

  // ----------------------------
  // Tag and data arrays
  // ----------------------------

  assign read_tag_0  = tag_array[0][req_addr.idx];
  assign read_tag_1  = tag_array[1][req_addr.idx];
  assign tag_match_0 = tag_ren && (read_tag_0 == req_addr.tag);
  assign tag_match_1 = tag_ren && (read_tag_1 == req_addr.tag);

  assign read_line = data_ren ? data_array[way_sel][req_addr.idx] : '0;

  // Refill takes the whole memory line, a write only its own word
  always_comb begin
    if (is_refill) begin
      write_line = memresp_line;
      word_en    = '1;
    end else begin
      for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
        write_line.words[w] = req_data;
      end
      word_en = `CACHE_WORDS_PER_LINE'(1) << req_addr.ofs;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_array[way_sel][req_addr.idx] <= req_addr.tag;
    end
    if (data_wen) begin
      for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
        if (word_en[w]) begin
          data_array[way_sel][req_addr.idx].words[w] <= write_line.words[w];
        end
      end
    end
  end

  // ----------------------------
  // Memory request
  // ----------------------------

  // Eviction goes to the victim's line, refill to the requested one
  assign mem_tag = (memreq_type == cache_msg_pkg::MEM_WRITE) ? evict_tag : req_addr.tag;
  assign memreq_addr = {mem_tag, req_addr.idx, {(`CACHE_OFS_BITS + 2){1'b0}}};
  assign memreq_data = evict_line.bits;

endmodule

/* verilog/blocking_cache.sv */
/*
 * Two-way set-associative write-back blocking cache
 */

`timescale 1ns/1ps
`include "cache_config.svh"

module blocking_cache (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cachereq_val,
  output logic                        cachereq_rdy,
  input  cache_msg_pkg::req_type_e     cachereq_type,
  input  logic [`CACHE_ADDR_BITS-1:0] cachereq_addr,
  input  logic [`CACHE_WORD_BITS-1:0] cachereq_data,
  output logic                        cacheresp_val,
  input  logic                        cacheresp_rdy,
  output cache_msg_pkg::req_type_e     cacheresp_type,
  output logic [`CACHE_WORD_BITS-1:0] cacheresp_data,
  output logic                        memreq_val,
  input  logic                        memreq_rdy,
  output cache_msg_pkg::mem_type_e     memreq_type,
  output logic [`CACHE_ADDR_BITS-1:0] memreq_addr,
  output logic [`CACHE_LINE_BITS-1:0] memreq_data,
  input  logic                        memresp_val,
  output logic                        memresp_rdy,
  input  logic [`CACHE_LINE_BITS-1:0] memresp_data
);

  logic                       cachereq_en;
  logic                       memresp_en;
  logic                       tag_ren;
  logic                       tag_wen;
  logic                       data_ren;
  logic                       data_wen;
  logic                       is_refill;
  logic                       read_data_reg_en;
  logic                       evict_reg_en;
  logic                       way_record_en;
  logic                       valid_we;
  logic                       dirty_we;
  logic                       dirty_in;
  logic                       lru_we;
  logic                       hit;
  logic                       victim_dirty;
  logic                       way_sel;
  logic                       req_is_write;
  logic                       tag_match_0;
  logic                       tag_match_1;
  logic [`CACHE_IDX_BITS-1:0] idx;

  cache_ctrl ctrl_i (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cacheresp_val, .cacheresp_rdy,
    .memreq_val, .memreq_rdy, .memreq_type, .memresp_val, .memresp_rdy,
    .cachereq_en, .memresp_en, .tag_ren, .tag_wen, .data_ren, .data_wen,
    .is_refill, .read_data_reg_en, .evict_reg_en,
    .way_record_en, .valid_we, .dirty_we, .dirty_in, .lru_we,
    .hit, .victim_dirty, .req_is_write
  );

  cache_way_state way_state_i (
    .clk, .reset, .idx, .tag_match_0, .tag_match_1,
    .way_record_en, .valid_we, .dirty_we, .dirty_in, .lru_we,
    .hit, .victim_dirty, .way_sel
  );

  cache_dpath dpath_i (
    .clk,
    .cachereq_en, .cachereq_type, .cachereq_addr, .cachereq_data,
    .memresp_en, .memresp_data,
    .tag_ren, .tag_wen, .data_ren, .data_wen, .is_refill,
    .read_data_reg_en, .evict_reg_en, .way_sel, .memreq_type,
    .tag_match_0, .tag_match_1, .idx, .req_is_write,
    .cacheresp_type, .cacheresp_data, .memreq_addr, .memreq_data
  );

endmodule

/* tb/mem_model.sv */
/*
 * Line memory for the cache testbench, random request stalls and response delay
 */

`timescale 1ns/1ps

module mem_model (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     memreq_val,
  output logic                     memreq_rdy,
  input  cache_msg_pkg::mem_type_e memreq_type,
  input  logic [31:0]              memreq_addr,
  input  logic [127:0]             memreq_data,
  output logic                     memresp_val,
  input  logic                     memresp_rdy,
  output logic [127:0]             memresp_data
);

  // Sparse word storage, untouched words follow the fill pattern
  logic [31:0] mem [logic [29:0]];
  logic        busy;
  int          delay;

  function automatic logic [31:0] word_at(input logic [29:0] a);
    if (mem.exists(a)) return mem[a];
    return {2'b00, a} ^ 32'h5a5a_0000;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      memreq_rdy   <= 1'b0;
      memresp_val  <= 1'b0;
      memresp_data <= '0;
      busy         <= 1'b0;
      delay        <= 0;
    end else if (busy) begin
      if (memresp_val) begin
        if (memresp_rdy) begin
          memresp_val <= 1'b0;
          busy        <= 1'b0;
        end
      end else if (delay == 0) begin
        memresp_val <= 1'b1;
      end else begin
        delay <= delay - 1;
      end
    end else if (memreq_val && memreq_rdy) begin
      busy       <= 1'b1;
      memreq_rdy <= 1'b0;
      delay      <= $urandom % 4;
      for (int w = 0; w < 4; w++) begin
        if (memreq_type == cache_msg_pkg::MEM_WRITE) begin
          mem[memreq_addr[31:2] + 30'(w)] = memreq_data[w*32 +: 32];
        end else begin
          memresp_data[w*32 +: 32] <= word_at(memreq_addr[31:2] + 30'(w));
        end
      end
    end else begin
      memreq_rdy <= 1'($urandom % 2);
    end
  end

endmodule

/* tb/blocking_cache_tb.sv */
/*
 * Testbench of the blocking cache with a reference word model and checking assertions
 */

`timescale 1ns/1ps

module blocking_cache_tb;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      cachereq_val;
  logic                      cachereq_rdy;
  cache_msg_pkg::req_type_e  cachereq_type;
  logic [31:0]               cachereq_addr;
  logic [31:0]               cachereq_data;
  logic                      cacheresp_val;
  logic                      cacheresp_rdy;
  cache_msg_pkg::req_type_e  cacheresp_type;
  logic [31:0]               cacheresp_data;
  logic                      memreq_val;
  logic                      memreq_rdy;
  cache_msg_pkg::mem_type_e  memreq_type;
  logic [31:0]               memreq_addr;
  logic [127:0]              memreq_data;
  logic                      memresp_val;
  logic                      memresp_rdy;
  logic [127:0]              memresp_data;

  // Reference words and a tag model of the two ways
  logic [31:0]  ref_mem [logic [29:0]];
  logic [24:0]  tag_m [2][8];
  logic         vld_m [2][8];
  logic         drt_m [2][8];
  logic         lru_m [8];
  logic         cur_write;
  logic         cur_hit;
  logic         cur_evict;
  logic         saw_read;
  logic         saw_write;
  logic [31:0]  exp_data;
  logic [31:0]  line_addr;
  logic [31:0]  evict_addr;
  logic [127:0] evict_data;
  int           lat;

  always #50 clk = !clk;

  blocking_cache dut_i (.*);

  mem_model mem_i (.*);

  // ------------------------------
  // Failure reporting
  // ------------------------------

  task automatic fail_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("%0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic logic [31:0] ref_word(input logic [29:0] a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return {2'b00, a} ^ 32'h5a5a_0000;
  endfunction

  task automatic model_access(input logic is_write, input logic [31:0] a, input logic [31:0] d);
    logic [24:0] tag;
    logic [2:0]  idx;
    logic        way;
    logic        hit;
    logic [29:0] base;
    int          w;
    tag = a[31:7];
    idx = a[6:4];
    hit = 1'b0;
    way = lru_m[idx];
    for (w = 0; w < 2; w++) begin
      if (vld_m[w][idx] && tag_m[w][idx] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    // Victim line as memory should receive it
    base = {tag_m[way][idx], idx, 2'b00};
    cur_hit    <= hit;
    cur_evict  <= !hit && vld_m[way][idx] && drt_m[way][idx];
    evict_addr <= {base, 2'b00};
    for (w = 0; w < 4; w++) begin
      evict_data[w*32 +: 32] <= ref_word(base + 30'(w));
    end
    if (!hit) begin
      tag_m[way][idx] = tag;
      vld_m[way][idx] = 1'b1;
      drt_m[way][idx] = 1'b0;
    end
    if (is_write) begin
      drt_m[way][idx] = 1'b1;
      ref_mem[a[31:2]] = d;
    end
    lru_m[idx] = !way;
    cur_write <= is_write;
    exp_data  <= ref_word(a[31:2]);
    line_addr <= {a[31:4], 4'b0000};
    lat       <= 1;
    saw_read  <= 1'b0;
    saw_write <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      lat       <= 0;
      cur_hit   <= 1'b0;
      saw_read  <= 1'b0;
      saw_write <= 1'b0;
    end else begin
      lat <= lat + 1;
      if (memreq_val && memreq_rdy) begin
        if (memreq_type == cache_msg_pkg::MEM_WRITE) saw_write <= 1'b1;
        else saw_read <= 1'b1;
      end
      if (cachereq_val && cachereq_rdy) begin
        model_access(cachereq_type == cache_msg_pkg::REQ_WRITE, cachereq_addr, cachereq_data);
      end
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy)
    else fail_plain("DUT is not idle after reset");

  read_data: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && cacheresp_rdy && !cur_write |-> cacheresp_data == exp_data)
    else fail_value("cacheresp_data", 128'($sampled(exp_data)),
                    128'($sampled(cacheresp_data)));

  // Response kind follows the accepted request
  resp_type: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && cacheresp_rdy |->
      (cacheresp_type == cache_msg_pkg::REQ_WRITE) == cur_write)
    else fail_value("cacheresp_type", 128'($sampled(cur_write)),
                    128'($sampled(cacheresp_type)));

  refill_addr: assert property (@(posedge clk) disable iff (reset)
    memreq_val && memreq_type == cache_msg_pkg::MEM_READ |-> memreq_addr == line_addr)
    else fail_value("memreq_addr", 128'($sampled(line_addr)), 128'($sampled(memreq_addr)));

  evict_addr_ok: assert property (@(posedge clk) disable iff (reset)
    memreq_val && memreq_type == cache_msg_pkg::MEM_WRITE |-> memreq_addr == evict_addr)
    else fail_value("memreq_addr", 128'($sampled(evict_addr)), 128'($sampled(memreq_addr)));

  evict_data_ok: assert property (@(posedge clk) disable iff (reset)
    memreq_val && memreq_type == cache_msg_pkg::MEM_WRITE |-> memreq_data == evict_data)
    else fail_value("memreq_data", $sampled(evict_data), $sampled(memreq_data));

  // Hit means no memory traffic, a dirty victim means one write
  mem_traffic: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && cacheresp_rdy |-> saw_read == !cur_hit && saw_write == cur_evict)
    else fail_plain("memory requests do not match the expected hit, refill and eviction");

  hit_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(cacheresp_val) && cur_hit |-> lat == 3)
    else fail_value("hit latency", 128'd3, 128'($sampled(lat)));

  resp_stable: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_data))
    else fail_plain("response dropped or changed while stalled");

  memreq_stable: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_addr)
      && $stable(memreq_data) && $stable(memreq_type))
    else fail_plain("memory request dropped or changed while stalled");

  // ------------------------------
  // Stimulus
  // ------------------------------

  function automatic logic [31:0] make_addr(input logic [24:0] tag, input logic [2:0] idx,
                                            input logic [1:0] ofs);
    return {tag, idx, ofs, 2'b00};
  endfunction

  task automatic access(input cache_msg_pkg::req_type_e t, input logic [31:0] a,
                        input logic [31:0] d);
    int n;
    @(posedge clk);
    cachereq_val  <= 1'b1;
    cachereq_type <= t;
    cachereq_addr <= a;
    cachereq_data <= d;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 1000) fail_plain("request was never accepted");
    end while (!cachereq_rdy);
    cachereq_val <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 1000) fail_plain("no response to the request");
    end while (!(cacheresp_val && cacheresp_rdy));
  endtask

  always @(posedge clk) begin
    if (!reset) cacheresp_rdy <= ($urandom % 4) != 0;
  end

  initial begin
    void'($urandom(32'hdea4_a550));
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = cache_msg_pkg::REQ_READ;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b0;
    for (int s = 0; s < 8; s++) begin
      vld_m[0][s] = 1'b0;
      vld_m[1][s] = 1'b0;
      drt_m[0][s] = 1'b0;
      drt_m[1][s] = 1'b0;
      lru_m[s]    = 1'b0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // Fill, hit, write then hit, all in set 3
    access(cache_msg_pkg::REQ_READ, make_addr(25'h10, 3'd3, 2'd0), '0);
    access(cache_msg_pkg::REQ_READ, make_addr(25'h10, 3'd3, 2'd0), '0);
    access(cache_msg_pkg::REQ_WRITE, make_addr(25'h10, 3'd3, 2'd1), 32'hcafe_0001);
    access(cache_msg_pkg::REQ_READ, make_addr(25'h10, 3'd3, 2'd1), '0);
    // A, B, A then C evicts the dirty B
    access(cache_msg_pkg::REQ_READ, make_addr(25'h20, 3'd3, 2'd0), '0);
    access(cache_msg_pkg::REQ_WRITE, make_addr(25'h20, 3'd3, 2'd2), 32'hbeef_0002);
    access(cache_msg_pkg::REQ_READ, make_addr(25'h10, 3'd3, 2'd0), '0);
    access(cache_msg_pkg::REQ_READ, make_addr(25'h30, 3'd3, 2'd0), '0);
    access(cache_msg_pkg::REQ_READ, make_addr(25'h20, 3'd3, 2'd2), '0);
    repeat (100) begin
      access(cache_msg_pkg::req_type_e'($urandom % 2),
             make_addr(25'($urandom % 4), 3'($urandom), 2'($urandom)), $urandom);
    end
    repeat (5) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* compile.f */
+incdir+verilog
verilog/cache_msg_pkg.sv
verilog/cache_line_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_way_state.sv
verilog/cache_dpath.sv
verilog/blocking_cache.sv
tb/mem_model.sv
tb/blocking_cache_tb.sv

/* Makefile */
# Verilator build and run of the blocking cache testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f \
	  --top-module blocking_cache_tb -Mdir $(OBJ_DIR) -o sim

run: compile
	./$(OBJ_DIR)/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
